/* hw/mini_tile_pkg.sv */
/*
 * Shared definitions for the compute-tile store path.
 * Widths, the address map, FIFO and memory sizes, the command opcodes
 * and the structs carried between sequencer, FIFO and store unit.
 * RTL and testbench refer to these by scoped name.
 */

package mini_tile_pkg;

  // Bus widths
  localparam int unsigned ADDR_W = 16;  // Byte address
  localparam int unsigned DATA_W = 32;  // Data word
  localparam int unsigned CNT_W  = 8;   // Fill word count

  // Word memory
  localparam int unsigned MEM_WORDS = 256;
  localparam int unsigned MEM_BYTES = MEM_WORDS * 4;      // First unmapped byte
  localparam int unsigned MEM_IDX_W = $clog2(MEM_WORDS);  // Word index bits

  // Write FIFO
  localparam int unsigned FIFO_DEPTH = 4;
  localparam int unsigned FIFO_PTR_W = $clog2(FIFO_DEPTH);
  localparam int unsigned FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);  // Holds 0..DEPTH

  // Special addresses, outside the memory window
  localparam logic [ADDR_W-1:0] EXIT_ADDR    = 16'hFF00;  // Low byte is the exit code
  localparam logic [ADDR_W-1:0] CONSOLE_ADDR = 16'hFF04;  // Low byte is a character

  // Command opcodes
  typedef enum logic [1:0] {
    OP_STORE = 2'd0,  // One word to addr
    OP_FILL  = 2'd1,  // count words, addr += 4 and data += 1 per word
    OP_PUTC  = 2'd2,  // Character to the console
    OP_EXIT  = 2'd3   // End of computation
  } opcode_e;

  // Command from the outside, 58 bits
  typedef struct packed {
    opcode_e             opcode;
    logic [ADDR_W-1:0]   addr;
    logic [DATA_W-1:0]   data;
    logic [CNT_W-1:0]    count;  // Only OP_FILL
  } cmd_t;

  // One word write on the internal bus, 48 bits
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
  } bus_wr_t;

endpackage

/* hw/store_sequencer.sv */
/*
 * Store sequencer.
 * Accepts one command while idle and expands it into word writes on
 * the internal bus. One write per cycle while the FIFO has room, the
 * current write is held under back-pressure. busy_o stays high from the
 * cycle after the strobe until the cycle after the last push.
 */

`timescale 1ns/100ps

module store_sequencer (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  logic                   cmd_valid_i,
  input  mini_tile_pkg::cmd_t    cmd_i,
  input  logic                   fifo_full_i,
  output logic                   push_o,
  output mini_tile_pkg::bus_wr_t wr_o,
  output logic                   busy_o
);

  typedef enum logic {
    IDLE,
    EMIT
  } state_e;

  state_e                             state_q;
  logic [mini_tile_pkg::CNT_W-1:0]    cnt_q;   // Words still to push
  mini_tile_pkg::bus_wr_t             run_q;   // Running address and data
  logic                               accept;

  // Strobes while busy are dropped
  assign accept = cmd_valid_i && (state_q == IDLE);

  // Push only with words left and room downstream
  assign push_o = (state_q == EMIT) && (cnt_q != '0) && !fifo_full_i;
  assign busy_o = (state_q == EMIT);
  assign wr_o   = run_q;

  // Control state
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (accept) begin
            state_q <= EMIT;
            // Only a fill carries its own length
            if (cmd_i.opcode == mini_tile_pkg::OP_FILL) cnt_q <= cmd_i.count;
            else                                         cnt_q <= 8'd1;
          end
        end
        EMIT: begin
          if (cnt_q == '0) begin
            state_q <= IDLE;  // Empty fill, nothing pushed
          end else if (push_o) begin
            cnt_q <= cnt_q - 8'd1;
            if (cnt_q == 8'd1) state_q <= IDLE;  // Last word went out
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Running write, payload only
  always_ff @(posedge clk) begin
    if (accept) begin
      run_q.data <= cmd_i.data;
      case (cmd_i.opcode)
        mini_tile_pkg::OP_PUTC: run_q.addr <= mini_tile_pkg::CONSOLE_ADDR;
        mini_tile_pkg::OP_EXIT: run_q.addr <= mini_tile_pkg::EXIT_ADDR;
        default:                run_q.addr <= cmd_i.addr;  // Store and fill
      endcase
    end else if (push_o) begin
      // Step to the next fill word, harmless for single writes
      run_q.addr <= run_q.addr + 16'd4;
      run_q.data <= run_q.data + 32'd1;
    end
  end

endmodule

/* hw/write_fifo.sv */
/*
 * Write FIFO between sequencer and store unit.
 * Circular buffer of bus writes with an occupancy counter.
 * Push and pop may happen in the same cycle. An entry pushed in one
 * cycle is at the head in the next. Users never push when full nor
 * pop when empty.
 */

`timescale 1ns/100ps

module write_fifo (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  logic                   push_i,
  input  mini_tile_pkg::bus_wr_t wr_i,
  input  logic                   pop_i,
  output mini_tile_pkg::bus_wr_t head_o,
  output logic                   full_o,
  output logic                   empty_o
);

  localparam logic [mini_tile_pkg::FIFO_PTR_W-1:0] LAST_SLOT =
    mini_tile_pkg::FIFO_PTR_W'(mini_tile_pkg::FIFO_DEPTH - 1);
  localparam logic [mini_tile_pkg::FIFO_CNT_W-1:0] FULL_CNT =
    mini_tile_pkg::FIFO_CNT_W'(mini_tile_pkg::FIFO_DEPTH);

  mini_tile_pkg::bus_wr_t                   buf_q [mini_tile_pkg::FIFO_DEPTH];
  logic [mini_tile_pkg::FIFO_PTR_W-1:0]     wr_ptr_q;
  logic [mini_tile_pkg::FIFO_PTR_W-1:0]     rd_ptr_q;
  logic [mini_tile_pkg::FIFO_CNT_W-1:0]     cnt_q;

  assign full_o  = (cnt_q == FULL_CNT);
  assign empty_o = (cnt_q == '0);
  assign head_o  = buf_q[rd_ptr_q];  // Valid only while not empty

  // Pointers and occupancy
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_i) begin
        // Explicit wrap, depth need not be a power of two
        wr_ptr_q <= (wr_ptr_q == LAST_SLOT) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == LAST_SLOT) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push_i, pop_i})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;  // Both or neither
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (push_i) buf_q[wr_ptr_q] <= wr_i;
  end

endmodule

/* hw/l2_store_unit.sv */
/*
 * L2 store unit.
 * Pops one write per cycle from the FIFO and decodes its address:
 * aligned memory words are committed, the console address emits a
 * character pulse, the exit address latches the exit code and raises
 * eoc_o. Anything else sets the sticky bad_addr_o. Also holds the
 * registered read port used by the testbench.
 */

`timescale 1ns/100ps

module l2_store_unit (
  input  logic                                clk,
  input  logic                                rst_n_i,
  input  logic                                empty_i,
  input  mini_tile_pkg::bus_wr_t              head_i,
  output logic                                pop_o,
  input  logic [mini_tile_pkg::ADDR_W-1:0]    rd_addr_i,
  output logic [mini_tile_pkg::DATA_W-1:0]    rd_data_o,
  output logic                                char_valid_o,
  output logic [7:0]                          char_o,
  output logic                                eoc_o,
  output logic [7:0]                          exit_code_o,
  output logic                                bad_addr_o
);

  localparam logic [mini_tile_pkg::ADDR_W-1:0] MEM_END =
    mini_tile_pkg::ADDR_W'(mini_tile_pkg::MEM_BYTES);

  logic [mini_tile_pkg::DATA_W-1:0]    mem_q [mini_tile_pkg::MEM_WORDS];
  logic [mini_tile_pkg::MEM_IDX_W-1:0] wr_idx;
  logic [mini_tile_pkg::MEM_IDX_W-1:0] rd_idx;
  logic                                hit_mem;
  logic                                hit_con;
  logic                                hit_exit;
  logic                                rd_in_range;

  // Drain whenever something is queued
  assign pop_o = !empty_i;

  // Address decode on the head entry
  assign hit_mem  = (head_i.addr < MEM_END) && (head_i.addr[1:0] == 2'b00);
  assign hit_con  = (head_i.addr == mini_tile_pkg::CONSOLE_ADDR);
  assign hit_exit = (head_i.addr == mini_tile_pkg::EXIT_ADDR);
  assign wr_idx   = head_i.addr[mini_tile_pkg::MEM_IDX_W+1:2];  // Byte to word

  // Read side, out of range reads as zero
  assign rd_in_range = (rd_addr_i < MEM_END);
  assign rd_idx      = rd_addr_i[mini_tile_pkg::MEM_IDX_W+1:2];

  // Word memory
  always_ff @(posedge clk) begin
    if (pop_o && hit_mem) mem_q[wr_idx] <= head_i.data;
  end

  // Registered read port
  always_ff @(posedge clk) begin
    if (rd_in_range) rd_data_o <= mem_q[rd_idx];
    else             rd_data_o <= '0;
  end

  // Console, end of computation and error flags
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      char_valid_o <= 1'b0;
      eoc_o        <= 1'b0;
      bad_addr_o   <= 1'b0;
    end else begin
      char_valid_o <= pop_o && hit_con;  // One cycle pulse per character
      if (pop_o && hit_exit) eoc_o <= 1'b1;  // Held until reset
      if (pop_o && !(hit_mem || hit_con || hit_exit)) begin
        bad_addr_o <= 1'b1;  // Unmapped or misaligned
      end
    end
  end

  // Payload bytes
  always_ff @(posedge clk) begin
    if (pop_o && hit_con)  char_o      <= head_i.data[7:0];
    if (pop_o && hit_exit) exit_code_o <= head_i.data[7:0];
  end

endmodule

/* hw/mini_tile_top.sv */
/*
 * Tile store path top level.
 * Command port feeds the sequencer, the write FIFO decouples it from
 * the L2 store unit. Read port, console and end-of-computation signals
 * come straight from the store unit.
 */

`timescale 1ns/100ps

module mini_tile_top (
  input  logic                                clk,
  input  logic                                rst_n_i,
  input  logic                                cmd_valid_i,
  input  mini_tile_pkg::cmd_t                 cmd_i,
  output logic                                busy_o,
  input  logic [mini_tile_pkg::ADDR_W-1:0]    rd_addr_i,
  output logic [mini_tile_pkg::DATA_W-1:0]    rd_data_o,
  output logic                                char_valid_o,
  output logic [7:0]                          char_o,
  output logic                                eoc_o,
  output logic [7:0]                          exit_code_o,
  output logic                                bad_addr_o
);

  logic                   push;       // Sequencer to FIFO
  mini_tile_pkg::bus_wr_t seq_wr;
  logic                   fifo_full;
  logic                   pop;        // Store unit to FIFO
  mini_tile_pkg::bus_wr_t fifo_head;
  logic                   fifo_empty;

  store_sequencer u_seq (
    .clk         ( clk         ),
    .rst_n_i     ( rst_n_i     ),
    .cmd_valid_i ( cmd_valid_i ),
    .cmd_i       ( cmd_i       ),
    .fifo_full_i ( fifo_full   ),
    .push_o      ( push        ),
    .wr_o        ( seq_wr      ),
    .busy_o      ( busy_o      )
  );

  write_fifo u_fifo (
    .clk     ( clk        ),
    .rst_n_i ( rst_n_i    ),
    .push_i  ( push       ),
    .wr_i    ( seq_wr     ),
    .pop_i   ( pop        ),
    .head_o  ( fifo_head  ),
    .full_o  ( fifo_full  ),
    .empty_o ( fifo_empty )
  );

  l2_store_unit u_l2 (
    .clk          ( clk          ),
    .rst_n_i      ( rst_n_i      ),
    .empty_i      ( fifo_empty   ),
    .head_i       ( fifo_head    ),
    .pop_o        ( pop          ),
    .rd_addr_i    ( rd_addr_i    ),
    .rd_data_o    ( rd_data_o    ),
    .char_valid_o ( char_valid_o ),
    .char_o       ( char_o       ),
    .eoc_o        ( eoc_o        ),
    .exit_code_o  ( exit_code_o  ),
    .bad_addr_o   ( bad_addr_o   )
  );

endmodule

/* verification/mini_tile_properties.sv */
/*
 * Protocol checks on the write FIFO.
 * Bound into every write_fifo instance. Flags a push into a full
 * buffer, a pop from an empty one, and full and empty seen together.
 * The number of failures is kept for the testbench to collect.
 */

`timescale 1ns/100ps

module mini_tile_properties (
  input logic clk,
  input logic rst_n_i,
  input logic push_i,
  input logic pop_i,
  input logic full_i,
  input logic empty_i
);

  int fail_cnt = 0;  // Failures so far

  // Producer must respect back-pressure
  a_no_push_when_full: assert property (
    @(posedge clk) disable iff (!rst_n_i) full_i |-> !push_i
  ) else begin
    $error("write FIFO pushed while full");
    fail_cnt++;
  end

  // Consumer only drains queued entries
  a_no_pop_when_empty: assert property (
    @(posedge clk) disable iff (!rst_n_i) empty_i |-> !pop_i
  ) else begin
    $error("write FIFO popped while empty");
    fail_cnt++;
  end

  // Occupancy cannot be both 0 and DEPTH
  a_full_empty_exclusive: assert property (
    @(posedge clk) disable iff (!rst_n_i) !(full_i && empty_i)
  ) else begin
    $error("write FIFO full and empty at once");
    fail_cnt++;
  end

endmodule

bind write_fifo mini_tile_properties u_props (
  .clk     ( clk     ),
  .rst_n_i ( rst_n_i ),
  .push_i  ( push_i  ),
  .pop_i   ( pop_i   ),
  .full_i  ( full_o  ),
  .empty_i ( empty_o )
);

/* verification/tile_vip.sv */
/*
 * Verification IP around the tile store path.
 * Collects console characters into a string, keeps a nanosecond timer
 * and offers bounded waits for an idle pipeline and for end of
 * computation. The testbench calls its tasks hierarchically.
 */

`timescale 1ns/100ps

module tile_vip (
  input logic       clk,
  input logic       busy_i,        // Sequencer busy
  input logic       fifo_empty_i,  // Write FIFO drained
  input logic       char_valid_i,
  input logic [7:0] char_i,
  input logic       eoc_i
);

  localparam int unsigned CLK_PERIOD_NS = 40;

  string           console_str = "";  // Everything printed so far
  longint unsigned timer_ns    = 0;   // Free running from time zero

  // Timer advances one period per falling edge
  always @(negedge clk) timer_ns <= timer_ns + CLK_PERIOD_NS;

  // Console monitor, pulse is stable around the falling edge
  always @(negedge clk) begin
    if (char_valid_i) console_str = $sformatf("%s%c", console_str, char_i);
  end

  task clear_console();
    console_str = "";
  endtask

  // Busy low, and with drain set also an empty FIFO
  task automatic wait_idle(input int max_cycles, input bit drain, output bit ok);
    int n;
    n  = 0;
    ok = 1'b0;
    while (!ok && n < max_cycles) begin
      @(negedge clk);
      ok = !busy_i && (!drain || fifo_empty_i);
      n++;
    end
  endtask

  // Returns the time spent waiting in ns
  task automatic wait_for_eoc(input int max_cycles, output bit ok,
                              output longint unsigned elapsed_ns);
    int              n;
    longint unsigned start_ns;
    n        = 0;
    ok       = 1'b0;
    start_ns = timer_ns;
    while (!ok && n < max_cycles) begin
      @(negedge clk);
      ok = eoc_i;
      n++;
    end
    elapsed_ns = timer_ns - start_ns;
  endtask

endmodule

/* verification/mini_tile_tb.sv */
/*
 * Testbench for the tile store path.
 * Drives commands on the falling edge from a table and from an LCG,
 * reads memory back through the read port and compares against a
 * model array. Covers stores, a long fill, console output, random
 * stores, a bad address and the exit write. One line per test.
 */

`timescale 1ns/100ps

module mini_tile_tb;

  localparam int unsigned IDLE_TIMEOUT = 400;  // Cycles
  localparam int unsigned EOC_TIMEOUT  = 100;
  localparam int unsigned N_DIRECTED   = 6;
  localparam int unsigned N_RANDOM     = 16;
  localparam int unsigned FILL_WORDS   = 64;
  localparam logic [15:0] FILL_BASE    = 16'h0100;
  localparam logic [31:0] FILL_DATA    = 32'hC0DE_0100;

  // One table row with command, wait flag and expected read
  typedef struct packed {
    mini_tile_pkg::cmd_t cmd;
    logic                wait_idle;  // Drain and check when set
    logic [15:0]         exp_addr;
    logic [31:0]         exp_data;
  } stim_t;

  logic                clk = 1'b0;
  logic                rst_n_i;
  logic                cmd_valid_i;
  mini_tile_pkg::cmd_t cmd_i;
  logic [15:0]         rd_addr_i;
  logic [31:0]         rd_data_o;
  logic                busy_o;
  logic                char_valid_o;
  logic [7:0]          char_o;
  logic                eoc_o;
  logic [7:0]          exit_code_o;
  logic                bad_addr_o;
  logic                fifo_empty;

  stim_t       stim_table [N_DIRECTED];
  logic [31:0] model_mem [mini_tile_pkg::MEM_WORDS];  // Last value written per word
  bit          model_valid [mini_tile_pkg::MEM_WORDS];
  logic [31:0] lcg_state = 32'h87197a1f;
  int          test_err, err_total, tests_ok, tests_bad;
  int          prop_fails_seen;  // FIFO assertion failures already counted

  always #20 clk = ~clk;  // 40 ns period

  assign fifo_empty = uut.u_fifo.empty_o;

  mini_tile_top uut (
    .clk          ( clk          ),
    .rst_n_i      ( rst_n_i      ),
    .cmd_valid_i  ( cmd_valid_i  ),
    .cmd_i        ( cmd_i        ),
    .busy_o       ( busy_o       ),
    .rd_addr_i    ( rd_addr_i    ),
    .rd_data_o    ( rd_data_o    ),
    .char_valid_o ( char_valid_o ),
    .char_o       ( char_o       ),
    .eoc_o        ( eoc_o        ),
    .exit_code_o  ( exit_code_o  ),
    .bad_addr_o   ( bad_addr_o   )
  );

  tile_vip u_vip (
    .clk          ( clk          ),
    .busy_i       ( busy_o       ),
    .fifo_empty_i ( fifo_empty   ),
    .char_valid_i ( char_valid_o ),
    .char_i       ( char_o       ),
    .eoc_i        ( eoc_o        )
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;  // Numerical Recipes constants
  endfunction

  function automatic mini_tile_pkg::cmd_t make_cmd(input mini_tile_pkg::opcode_e op,
      input logic [15:0] addr, input logic [31:0] data, input logic [7:0] count);
    mini_tile_pkg::cmd_t c;
    c.opcode = op;
    c.addr   = addr;
    c.data   = data;
    c.count  = count;
    return c;
  endfunction

  function automatic stim_t store_entry(input logic [15:0] addr, input logic [31:0] data,
      input logic wait_idle, input logic [15:0] exp_addr, input logic [31:0] exp_data);
    stim_t e;
    e.cmd       = make_cmd(mini_tile_pkg::OP_STORE, addr, data, 8'd0);
    e.wait_idle = wait_idle;
    e.exp_addr  = exp_addr;
    e.exp_data  = exp_data;
    return e;
  endfunction

  task note_write(input logic [15:0] addr, input logic [31:0] data);
    model_mem[addr[9:2]]   = data;  // Word index of a byte address
    model_valid[addr[9:2]] = 1'b1;
  endtask

  // One-cycle strobe launched on the falling edge
  task send_cmd(input mini_tile_pkg::cmd_t c);
    @(negedge clk);
    cmd_i       = c;
    cmd_valid_i = 1'b1;
    @(negedge clk);
    cmd_valid_i = 1'b0;
  endtask

  task settle(input bit drain);
    bit ok;
    u_vip.wait_idle(IDLE_TIMEOUT, drain, ok);
    assert (ok) else begin
      $display("Timeout at %0t ns: DUT did not go idle within %0d cycles", $time, IDLE_TIMEOUT);
      test_err++;
    end
  endtask

  task check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    assert (got === exp) else begin
      $display("MISMATCH at %0t ns: %s got 0x%08h expected 0x%08h", $time, what, got, exp);
      test_err++;
    end
  endtask

  // Address on one falling edge and data one cycle later
  task check_word(input logic [15:0] addr, input logic [31:0] exp);
    @(negedge clk);
    rd_addr_i = addr;
    @(negedge clk);
    check_value(rd_data_o, exp, $sformatf("word at 0x%04h", addr));
  endtask

  task check_model();
    for (int i = 0; i < mini_tile_pkg::MEM_WORDS; i++) begin
      if (model_valid[i]) check_word(16'(i * 4), model_mem[i]);
    end
  endtask

  task end_test(input string name);
    int new_fails;
    // Bound FIFO checks that fired during this test
    new_fails = uut.u_fifo.u_props.fail_cnt - prop_fails_seen;
    assert (new_fails == 0) else begin
      $display("FIFO protocol assertions failed %0d times during test %s", new_fails, name);
      test_err += new_fails;
    end
    prop_fails_seen = uut.u_fifo.u_props.fail_cnt;
    if (test_err == 0) begin
      $display("Test %-14s ok", name);
      tests_ok++;
    end else begin
      $display("Test %-14s failed with %0d errors", name, test_err);
      tests_bad++;
    end
    err_total += test_err;
    test_err = 0;
  endtask

  initial begin
    string              msg;
    logic [15:0]        addr;
    logic [31:0]        data;
    logic [15:0]        rand_addrs[$];
    bit                 ok;
    longint unsigned    eoc_ns;
    // All DUT inputs defined from time zero
    rst_n_i         = 1'b0;
    cmd_valid_i     = 1'b0;
    cmd_i           = '0;
    rd_addr_i       = '0;
    test_err        = 0;
    err_total       = 0;
    tests_ok        = 0;
    tests_bad       = 0;
    prop_fails_seen = 0;
    // Row 1 is not waited on and row 5 reads it back
    stim_table[0] = store_entry(16'h0000, 32'h1111_0000, 1'b1, 16'h0000, 32'h1111_0000);
    stim_table[1] = store_entry(16'h0004, 32'hDEAD_BEEF, 1'b0, 16'h0000, 32'h0);
    stim_table[2] = store_entry(16'h00FC, 32'h5EA1_00FC, 1'b1, 16'h00FC, 32'h5EA1_00FC);
    stim_table[3] = store_entry(16'h0200, 32'h5EA1_0200, 1'b1, 16'h0200, 32'h5EA1_0200);
    stim_table[4] = store_entry(16'h03FC, 32'hFFFF_0001, 1'b1, 16'h03FC, 32'hFFFF_0001);
    stim_table[5] = store_entry(16'h0010, 32'h0BAD_CAFE, 1'b1, 16'h0004, 32'hDEAD_BEEF);

    repeat (16) @(negedge clk);
    rst_n_i = 1'b1;

    // Outputs quiet after reset
    check_value(busy_o, 0, "busy_o");
    check_value(char_valid_o, 0, "char_valid_o");
    check_value(eoc_o, 0, "eoc_o");
    check_value(bad_addr_o, 0, "bad_addr_o");
    end_test("reset");

    for (int i = 0; i < N_DIRECTED; i++) begin
      send_cmd(stim_table[i].cmd);
      note_write(stim_table[i].cmd.addr, stim_table[i].cmd.data);
      settle(stim_table[i].wait_idle);
      if (stim_table[i].wait_idle) check_word(stim_table[i].exp_addr, stim_table[i].exp_data);
    end
    end_test("single stores");

    // Word k gets base + 4k and data + k while neighbours stay untouched
    send_cmd(make_cmd(mini_tile_pkg::OP_FILL, FILL_BASE, FILL_DATA, 8'(FILL_WORDS)));
    for (int k = 0; k < FILL_WORDS; k++) note_write(16'(FILL_BASE + 4 * k), FILL_DATA + k);
    settle(1'b1);
    for (int k = 0; k < FILL_WORDS; k++) check_word(16'(FILL_BASE + 4 * k), FILL_DATA + k);
    check_word(16'h00FC, 32'h5EA1_00FC);
    check_word(16'h0200, 32'h5EA1_0200);
    end_test("fill");

    msg = "tile up";
    u_vip.clear_console();
    for (int i = 0; i < msg.len(); i++) begin
      send_cmd(make_cmd(mini_tile_pkg::OP_PUTC, 16'h0, {24'h0, msg[i]}, 8'd0));
      settle(1'b1);
    end
    @(negedge clk);  // Last pulse seen by the monitor
    assert (u_vip.console_str == msg) else begin
      $display("MISMATCH at %0t ns: console got \"%s\" expected \"%s\"",
               $time, u_vip.console_str, msg);
      test_err++;
    end
    end_test("console");

    for (int i = 0; i < N_RANDOM; i++) begin
      lcg_state = lcg_next(lcg_state);
      addr      = lcg_state[15:0] & 16'h03FC;  // Aligned and inside memory
      lcg_state = lcg_next(lcg_state);
      data      = lcg_state;
      rand_addrs.push_back(addr);
      send_cmd(make_cmd(mini_tile_pkg::OP_STORE, addr, data, 8'd0));
      note_write(addr, data);
      settle(1'b0);
    end
    settle(1'b1);
    foreach (rand_addrs[i]) check_word(rand_addrs[i], model_mem[rand_addrs[i][9:2]]);
    end_test("random stores");

    check_value(bad_addr_o, 0, "bad_addr_o before stray write");
    send_cmd(make_cmd(mini_tile_pkg::OP_STORE, 16'h0802, 32'hBAD0_0802, 8'd0));
    settle(1'b1);
    @(negedge clk);
    check_value(bad_addr_o, 1, "bad_addr_o");
    check_model();  // Nothing written anywhere
    end_test("bad address");

    send_cmd(make_cmd(mini_tile_pkg::OP_EXIT, 16'h0, 32'h0000_002A, 8'd0));
    u_vip.wait_for_eoc(EOC_TIMEOUT, ok, eoc_ns);
    assert (ok) else begin
      $display("Timeout at %0t ns: eoc_o not raised within %0d cycles", $time, EOC_TIMEOUT);
      test_err++;
    end
    check_value(eoc_o, 1, "eoc_o");
    check_value(exit_code_o, 8'h2A, "exit_code_o");
    $display("End of computation after %0d ns", eoc_ns);
    end_test("exit");

    $display("Summary: %0d tests ok, %0d failed, %0d errors", tests_ok, tests_bad, err_total);
    if (err_total == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* mini_tile.f */
hw/mini_tile_pkg.sv
hw/store_sequencer.sv
hw/write_fifo.sv
hw/l2_store_unit.sv
hw/mini_tile_top.sv
verification/mini_tile_properties.sv
verification/tile_vip.sv
verification/mini_tile_tb.sv

/* Bender.yml */
package:
  name: mini_tile

sources:
  # Design, package first
  - hw/mini_tile_pkg.sv
  - hw/store_sequencer.sv
  - hw/write_fifo.sv
  - hw/l2_store_unit.sv
  - hw/mini_tile_top.sv
  # Verification
  - target: simulation
    files:
      - verification/mini_tile_properties.sv
      - verification/tile_vip.sv
      - verification/mini_tile_tb.sv
